// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pe_periph_tb
RTL_TOP   ?= pe_periph_top
FILELIST  ?= pe_periph_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/ni_link_tx.sv ====
`timescale 1ns/1ps

module ni_link_tx
    import pe_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,

    input  logic [DATA_W-1:0] fifo_data_i,
    input  logic              fifo_empty_i,
    input  logic              noc_credit_i,

    output logic              pop_o,
    output logic              noc_tx_o,
    output logic [DATA_W-1:0] noc_data_o,
    output logic              idle_o,
    output logic [CNT_W-1:0]  sent_count_o
);

    logic valid_q;
    logic accept;

    // A flit leaves when tx and credit meet
    assign accept = valid_q && noc_credit_i;

    // Refill when empty or when the current flit goes out
    assign pop_o = (!valid_q || accept) && !fifo_empty_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q      <= 1'b0;
            sent_count_o <= '0;
        end else begin
            valid_q <= pop_o || (valid_q && !accept);
            if (accept) begin
                sent_count_o <= sent_count_o + 1'b1;
            end
        end
    end

    // Held steady while credit is low
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            noc_data_o <= fifo_data_i;
        end
    end

    assign noc_tx_o = valid_q;
    assign idle_o   = !valid_q;

endmodule

// ==== logic/ni_mmr.sv ====
`timescale 1ns/1ps

module ni_mmr
    import pe_pkg::*;
#(
    parameter int NI_FIFO_DEPTH = 8
)
(
    input  logic                               clk_i,
    input  logic                               rst_ni,

    input  logic                               en_i,
    input  logic                               we_i,
    input  ni_reg_e                            addr_i,
    input  logic [DATA_W-1:0]                  wdata_i,

    input  logic                               fifo_full_i,
    input  logic [$clog2(NI_FIFO_DEPTH+1)-1:0] fifo_count_i,
    input  logic                               link_idle_i,
    input  logic [CNT_W-1:0]                   sent_count_i,

    output logic [DATA_W-1:0]                  rdata_o,
    output logic                               push_o,
    output logic [DATA_W-1:0]                  flit_o,
    output logic                               irq_o
);

    logic       tx_wr;
    logic       overflow_q;
    logic       irq_en_q;
    logic [7:0] count8;

    assign tx_wr  = en_i && we_i && (addr_i == NI_TX_DATA);
    assign push_o = tx_wr && !fifo_full_i;
    assign flit_o = wdata_i;
    assign count8 = 8'(fifo_count_i);

    // Sticky overflow, write a one to STATUS bit 0 to clear it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            overflow_q <= 1'b0;
        end else if (tx_wr && fifo_full_i) begin
            overflow_q <= 1'b1;
        end else if (en_i && we_i && (addr_i == NI_STATUS) && wdata_i[0]) begin
            overflow_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_en_q <= 1'b0;
        end else if (en_i && we_i && (addr_i == NI_IRQ_EN)) begin
            irq_en_q <= wdata_i[0];
        end
    end

    // Raised while the whole send pipe has drained
    assign irq_o = irq_en_q && (fifo_count_i == '0) && link_idle_i;

    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            case (addr_i)
                NI_STATUS: rdata_o <= {sent_count_i, count8, 7'b0, overflow_q};
                NI_IRQ_EN: rdata_o <= {31'b0, irq_en_q};
                default:   rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== logic/ni_send_fifo.sv ====
`timescale 1ns/1ps

module ni_send_fifo
    import pe_pkg::*;
#(
    parameter int NI_FIFO_DEPTH = 8
)
(
    input  logic                               clk_i,
    input  logic                               rst_ni,

    input  logic                               push_i,
    input  logic [DATA_W-1:0]                  data_i,
    input  logic                               pop_i,

    output logic [DATA_W-1:0]                  data_o,
    output logic                               full_o,
    output logic                               empty_o,
    output logic [$clog2(NI_FIFO_DEPTH+1)-1:0] count_o
);

    localparam int PTR_W = $clog2(NI_FIFO_DEPTH);
    localparam int CW    = $clog2(NI_FIFO_DEPTH + 1);

    logic [DATA_W-1:0] mem [NI_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CW-1:0]     count_q;
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count_q == CW'(NI_FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign count_o = count_q;
    assign data_o  = mem[rd_ptr_q];

    // Push while full is dropped here, the register block flags it
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // Pointers wrap on their own with a power of two depth
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== logic/pe_bus_decoder.sv ====
`timescale 1ns/1ps

module pe_bus_decoder
    import pe_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,

    input  logic              bus_en_i,
    input  logic [3:0]        bus_we_i,
    input  logic [ADDR_W-1:0] bus_addr_i,

    input  logic [DATA_W-1:0] dmem_data_i,
    input  logic [DATA_W-1:0] rtc_rdata_i,
    input  logic [DATA_W-1:0] plic_rdata_i,
    input  logic [DATA_W-1:0] ni_rdata_i,

    output logic              dmem_en_o,
    output logic              rtc_en_o,
    output logic              plic_en_o,
    output logic              ni_en_o,
    output logic              periph_we_o,
    output logic [DATA_W-1:0] bus_rdata_o
);

    region_e region;

    assign region = region_e'(bus_addr_i[ADDR_W-1:ADDR_W-8]);

    // Unmapped regions raise no enable
    assign dmem_en_o = bus_en_i && (region == REGION_DMEM);
    assign rtc_en_o  = bus_en_i && (region == REGION_RTC);
    assign plic_en_o = bus_en_i && (region == REGION_PLIC);
    assign ni_en_o   = bus_en_i && (region == REGION_NI);

    // Any byte strobe makes it a write for the peripherals
    assign periph_we_o = |bus_we_i;

    ////////////////////////////////////////////////////////////
    // Read data return
    ////////////////////////////////////////////////////////////

    // Peripheral read words appear one cycle after the access
    logic rtc_sel_q;
    logic plic_sel_q;
    logic ni_sel_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
            ni_sel_q   <= 1'b0;
        end else begin
            rtc_sel_q  <= rtc_en_o;
            plic_sel_q <= plic_en_o;
            ni_sel_q   <= ni_en_o;
        end
    end

    // Data memory answers in the same cycle
    always_comb begin
        if (rtc_sel_q) begin
            bus_rdata_o = rtc_rdata_i;
        end else if (plic_sel_q) begin
            bus_rdata_o = plic_rdata_i;
        end else if (ni_sel_q) begin
            bus_rdata_o = ni_rdata_i;
        end else begin
            bus_rdata_o = dmem_data_i;
        end
    end

endmodule

// ==== logic/pe_periph_top.sv ====
`timescale 1ns/1ps

module pe_periph_top
    import pe_pkg::*;
#(
    parameter int NI_FIFO_DEPTH = 8
)
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // CPU-side bus
    input  logic                  bus_en_i,
    input  logic [3:0]            bus_we_i,
    input  logic [ADDR_W-1:0]     bus_addr_i,
    input  logic [DATA_W-1:0]     bus_wdata_i,
    output logic [DATA_W-1:0]     bus_rdata_o,
    input  logic                  irq_ack_i,

    // Data memory
    output logic                  dmem_en_o,
    output logic [3:0]            dmem_we_o,
    output logic [MEM_ADDR_W-1:0] dmem_addr_o,
    output logic [DATA_W-1:0]     dmem_wdata_o,
    input  logic [DATA_W-1:0]     dmem_data_i,

    output logic                  mti_o,
    output logic                  mei_o,

    // NoC output port
    output logic                  noc_tx_o,
    input  logic                  noc_credit_i,
    output logic [DATA_W-1:0]     noc_data_o
);

    localparam int FIFO_CNT_W = $clog2(NI_FIFO_DEPTH + 1);

    logic                  rtc_en;
    logic                  plic_en;
    logic                  ni_en;
    logic                  periph_we;
    logic [DATA_W-1:0]     rtc_rdata;
    logic [DATA_W-1:0]     plic_rdata;
    logic [DATA_W-1:0]     ni_rdata;
    logic                  ni_irq;

    logic                  fifo_push;
    logic                  fifo_pop;
    logic [DATA_W-1:0]     push_flit;
    logic [DATA_W-1:0]     head_flit;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic                  link_idle;
    logic [CNT_W-1:0]      sent_count;

    assign dmem_we_o    = bus_we_i;
    assign dmem_addr_o  = bus_addr_i[MEM_ADDR_W-1:0];
    assign dmem_wdata_o = bus_wdata_i;

    ////////////////////////////////////////////////////////////
    // Address decode and peripherals
    ////////////////////////////////////////////////////////////

    pe_bus_decoder u_decoder (
        .clk_i        (clk_i      ),
        .rst_ni       (rst_ni     ),
        .bus_en_i     (bus_en_i   ),
        .bus_we_i     (bus_we_i   ),
        .bus_addr_i   (bus_addr_i ),
        .dmem_data_i  (dmem_data_i),
        .rtc_rdata_i  (rtc_rdata  ),
        .plic_rdata_i (plic_rdata ),
        .ni_rdata_i   (ni_rdata   ),
        .dmem_en_o    (dmem_en_o  ),
        .rtc_en_o     (rtc_en     ),
        .plic_en_o    (plic_en    ),
        .ni_en_o      (ni_en      ),
        .periph_we_o  (periph_we  ),
        .bus_rdata_o  (bus_rdata_o)
    );

    pe_rtc u_rtc (
        .clk_i   (clk_i                       ),
        .rst_ni  (rst_ni                      ),
        .en_i    (rtc_en                      ),
        .we_i    (periph_we                   ),
        .addr_i  (rtc_reg_e'(bus_addr_i[3:2]) ),
        .wdata_i (bus_wdata_i                 ),
        .rdata_o (rtc_rdata                   ),
        .mti_o   (mti_o                       )
    );

    pe_plic u_plic (
        .clk_i     (clk_i                       ),
        .rst_ni    (rst_ni                      ),
        .en_i      (plic_en                     ),
        .we_i      (periph_we                   ),
        .addr_i    (plic_reg_e'(bus_addr_i[3:2])),
        .wdata_i   (bus_wdata_i                 ),
        .src_irq_i (ni_irq                      ),
        .irq_ack_i (irq_ack_i                   ),
        .rdata_o   (plic_rdata                  ),
        .mei_o     (mei_o                       )
    );

    ////////////////////////////////////////////////////////////
    // NI send path
    ////////////////////////////////////////////////////////////

    ni_mmr #(
        .NI_FIFO_DEPTH (NI_FIFO_DEPTH)
    ) u_ni_mmr (
        .clk_i        (clk_i                     ),
        .rst_ni       (rst_ni                    ),
        .en_i         (ni_en                     ),
        .we_i         (periph_we                 ),
        .addr_i       (ni_reg_e'(bus_addr_i[3:2])),
        .wdata_i      (bus_wdata_i               ),
        .fifo_full_i  (fifo_full                 ),
        .fifo_count_i (fifo_count                ),
        .link_idle_i  (link_idle                 ),
        .sent_count_i (sent_count                ),
        .rdata_o      (ni_rdata                  ),
        .push_o       (fifo_push                 ),
        .flit_o       (push_flit                 ),
        .irq_o        (ni_irq                    )
    );

    ni_send_fifo #(
        .NI_FIFO_DEPTH (NI_FIFO_DEPTH)
    ) u_send_fifo (
        .clk_i   (clk_i     ),
        .rst_ni  (rst_ni    ),
        .push_i  (fifo_push ),
        .data_i  (push_flit ),
        .pop_i   (fifo_pop  ),
        .data_o  (head_flit ),
        .full_o  (fifo_full ),
        .empty_o (fifo_empty),
        .count_o (fifo_count)
    );

    ni_link_tx u_link_tx (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .fifo_data_i  (head_flit   ),
        .fifo_empty_i (fifo_empty  ),
        .noc_credit_i (noc_credit_i),
        .pop_o        (fifo_pop    ),
        .noc_tx_o     (noc_tx_o    ),
        .noc_data_o   (noc_data_o  ),
        .idle_o       (link_idle   ),
        .sent_count_o (sent_count  )
    );

endmodule

// ==== logic/pe_pkg.sv ====
package pe_pkg;

    ////////////////////////////////////////////////////////////
    // Bus and link widths
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int MEM_ADDR_W = 24;

    // Width of the sent-flit counter on the NoC link
    localparam int CNT_W      = 16;

    ////////////////////////////////////////////////////////////
    // Memory map, top address byte
    ////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        REGION_IMEM = 8'h00,
        REGION_DMEM = 8'h01,
        REGION_RTC  = 8'h02,
        REGION_PLIC = 8'h04,
        REGION_NI   = 8'h08
    } region_e;

    ////////////////////////////////////////////////////////////
    // Register word indices, address bits 3:2
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RTC_MTIME_LO    = 2'd0,
        RTC_MTIME_HI    = 2'd1,
        RTC_MTIMECMP_LO = 2'd2,
        RTC_MTIMECMP_HI = 2'd3
    } rtc_reg_e;

    typedef enum logic [1:0] {
        PLIC_PENDING = 2'd0,
        PLIC_ENABLE  = 2'd1,
        PLIC_CLAIM   = 2'd2
    } plic_reg_e;

    typedef enum logic [1:0] {
        NI_TX_DATA = 2'd0,
        NI_STATUS  = 2'd1,
        NI_IRQ_EN  = 2'd2
    } ni_reg_e;

endpackage

// ==== logic/pe_plic.sv ====
`timescale 1ns/1ps

module pe_plic
    import pe_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,

    input  logic              en_i,
    input  logic              we_i,
    input  plic_reg_e         addr_i,
    input  logic [DATA_W-1:0] wdata_i,

    input  logic              src_irq_i,
    input  logic              irq_ack_i,

    output logic [DATA_W-1:0] rdata_o,
    output logic              mei_o
);

    logic pending_q;
    logic enable_q;

    // Acknowledge wins, a source still high sets it again next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (irq_ack_i) begin
            pending_q <= 1'b0;
        end else if (src_irq_i) begin
            pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (en_i && we_i && (addr_i == PLIC_ENABLE)) begin
            enable_q <= wdata_i[0];
        end
    end

    assign mei_o = pending_q && enable_q;

    // Claim reports the pending source
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            case (addr_i)
                PLIC_PENDING: rdata_o <= {31'b0, pending_q};
                PLIC_ENABLE:  rdata_o <= {31'b0, enable_q};
                PLIC_CLAIM:   rdata_o <= {31'b0, pending_q};
                default:      rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== logic/pe_rtc.sv ====
`timescale 1ns/1ps

module pe_rtc
    import pe_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,

    input  logic              en_i,
    input  logic              we_i,
    input  rtc_reg_e          addr_i,
    input  logic [DATA_W-1:0] wdata_i,

    output logic [DATA_W-1:0] rdata_o,
    output logic              mti_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        wr;

    assign wr = en_i && we_i;

    // Free-running tick counter
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // Compare starts at all ones so the timer stays quiet after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (wr) begin
            case (addr_i)
                RTC_MTIMECMP_LO: mtimecmp_q[31:0]  <= wdata_i;
                RTC_MTIMECMP_HI: mtimecmp_q[63:32] <= wdata_i;
                default: ;
            endcase
        end
    end

    assign mti_o = (mtime_q >= mtimecmp_q);

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // Counter value is the one present at the access edge
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            case (addr_i)
                RTC_MTIME_LO:    rdata_o <= mtime_q[31:0];
                RTC_MTIME_HI:    rdata_o <= mtime_q[63:32];
                RTC_MTIMECMP_LO: rdata_o <= mtimecmp_q[31:0];
                default:         rdata_o <= mtimecmp_q[63:32];
            endcase
        end
    end

endmodule

// ==== pe_periph_top.f ====
logic/pe_pkg.sv
logic/pe_bus_decoder.sv
logic/pe_rtc.sv
logic/pe_plic.sv
logic/ni_mmr.sv
logic/ni_send_fifo.sv
logic/ni_link_tx.sv
logic/pe_periph_top.sv
tb/pe_clock_gen.sv
tb/pe_periph_tb.sv

// ==== tb/pe_clock_gen.sv ====
`timescale 1ns/1ps

module pe_clock_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 3
)
(
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// ==== tb/pe_periph_tb.sv ====
`timescale 1ns/1ps

module pe_periph_tb
    import pe_pkg::*;
;

    localparam int DEPTH = 8;

    typedef enum {
        OP_WRITE, OP_READ, OP_WAIT, OP_ACK, OP_MTI, OP_MEI,
        OP_CREDIT, OP_DRAIN, OP_MARK, OP_DELTA, OP_CMP_REL
    } op_e;

    typedef struct {
        op_e         kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        bit          care;
        bit          flit;
    } step_t;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  bus_en_i;
    logic [3:0]            bus_we_i;
    logic [ADDR_W-1:0]     bus_addr_i;
    logic [DATA_W-1:0]     bus_wdata_i;
    logic [DATA_W-1:0]     bus_rdata_o;
    logic                  irq_ack_i;
    logic                  dmem_en_o;
    logic [3:0]            dmem_we_o;
    logic [MEM_ADDR_W-1:0] dmem_addr_o;
    logic [DATA_W-1:0]     dmem_wdata_o;
    logic [DATA_W-1:0]     dmem_data_i;
    logic                  mti_o;
    logic                  mei_o;
    logic                  noc_tx_o;
    logic                  noc_credit_i;
    logic [DATA_W-1:0]     noc_data_o;

    step_t             steps[$];
    logic [DATA_W-1:0] exp_flits[$];
    logic [DATA_W-1:0] mem_model [64];
    logic [1:0]        credit_mode;
    logic [31:0]       mark_val;
    int                mark_cyc;
    int                cycle_cnt;
    int                pass_cnt;
    int                fail_cnt;
    bit                tests_ready;

    pe_clock_gen #(.PERIOD_NS(8), .RST_CYCLES(3)) u_clk (.clk_o(clk_i), .rst_no(rst_ni));

    pe_periph_top #(.NI_FIFO_DEPTH(DEPTH)) dut0 (.*);

    ////////////////////////////////////////////////////////////
    // Memory model, NoC sink, credit driver
    ////////////////////////////////////////////////////////////

    // Unwritten words outside the window come from the fill pattern
    function automatic logic [31:0] fill_word(logic [23:0] a);
        return {a[7:0], a} ^ 32'h5A5A_0000;
    endfunction

    assign dmem_data_i = (dmem_addr_o[23:8] == '0) ? mem_model[dmem_addr_o[7:2]]
                                                   : fill_word(dmem_addr_o);

    always @(posedge clk_i) begin
        if (dmem_en_o && |dmem_we_o && dmem_addr_o[23:8] == '0) begin
            mem_model[dmem_addr_o[7:2]] <= dmem_wdata_o;
        end
        cycle_cnt <= cycle_cnt + 1;
    end

    // Mode 2 gives a random credit every cycle
    always @(posedge clk_i) begin
        if (credit_mode == 2'd2) begin
            noc_credit_i <= 1'($urandom_range(0, 1));
        end else begin
            noc_credit_i <= credit_mode[0];
        end
    end

    always @(negedge clk_i) begin
        if (rst_ni && noc_tx_o && noc_credit_i) begin
            if (exp_flits.size() == 0) begin
                fail_cnt++;
                $display("flit seen on noc_data_o while none was expected");
            end else begin
                check_flit("noc_data_o", noc_data_o, exp_flits.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_cnt++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end else begin
            pass_cnt++;
            $display("ok %s %h", name, got);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_cnt++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end else begin
            pass_cnt++;
            $display("ok %s %h", name, got);
        end
    endtask

    task automatic check_flit(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_cnt++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end else begin
            pass_cnt++;
            $display("ok %s flit %h", name, got);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Table and its execution
    ////////////////////////////////////////////////////////////

    function automatic void add_step(op_e k, logic [31:0] a, logic [31:0] d,
                                     logic [31:0] e, bit c, bit f);
        step_t s;
        s.kind  = k;
        s.addr  = a;
        s.wdata = d;
        s.exp   = e;
        s.care  = c;
        s.flit  = f;
        steps.push_back(s);
    endfunction

    task automatic bus_write(logic [31:0] a, logic [31:0] d, bit f);
        @(posedge clk_i);
        bus_en_i    <= 1'b1;
        bus_we_i    <= 4'hF;
        bus_addr_i  <= a;
        bus_wdata_i <= d;
        if (f) begin
            exp_flits.push_back(d);
        end
        @(negedge clk_i);
        if (a[31:24] == 8'h01) begin
            check_bit("dmem_en_o", dmem_en_o, 1'b1);
            check_word("dmem_addr_o", 32'(dmem_addr_o), {8'h00, a[23:0]});
            check_word("dmem_we_o", 32'(dmem_we_o), 32'hF);
            check_word("dmem_wdata_o", dmem_wdata_o, d);
        end else if (a[31:24] == 8'h10) begin
            check_bit("dmem_en_o", dmem_en_o, 1'b0);
        end
        @(posedge clk_i);
        bus_en_i <= 1'b0;
        bus_we_i <= 4'h0;
    endtask

    task automatic run_step(step_t s);
        logic [31:0] got;
        int          edge_cyc;
        case (s.kind)
            OP_WRITE: bus_write(s.addr, s.wdata, s.flit);
            OP_CMP_REL: bus_write(s.addr, mark_val + 32'(cycle_cnt - mark_cyc) + s.wdata, 1'b0);
            OP_READ, OP_MARK, OP_DELTA: begin
                @(posedge clk_i);
                bus_en_i   <= 1'b1;
                bus_we_i   <= 4'h0;
                bus_addr_i <= s.addr;
                if (s.addr[31:24] == 8'h01) begin
                    @(negedge clk_i);
                    got = bus_rdata_o;
                    @(posedge clk_i);
                    edge_cyc = cycle_cnt;
                    bus_en_i <= 1'b0;
                end else begin
                    @(posedge clk_i);
                    edge_cyc = cycle_cnt;
                    bus_en_i <= 1'b0;
                    @(negedge clk_i);
                    got = bus_rdata_o;
                end
                if (s.kind == OP_MARK) begin
                    mark_val = got;
                    mark_cyc = edge_cyc;
                end else if (s.kind == OP_DELTA) begin
                    check_word("bus_rdata_o", got, mark_val + 32'(edge_cyc - mark_cyc));
                end else if (s.care) begin
                    check_word("bus_rdata_o", got, s.exp);
                end
            end
            OP_WAIT: repeat (s.wdata) @(posedge clk_i);
            OP_ACK: begin
                @(posedge clk_i);
                irq_ack_i <= 1'b1;
                @(posedge clk_i);
                irq_ack_i <= 1'b0;
                @(negedge clk_i);
                check_bit("mei_o", mei_o, s.exp[0]);
            end
            OP_MTI, OP_MEI: begin
                @(posedge clk_i);
                @(negedge clk_i);
                if (s.kind == OP_MTI) begin
                    check_bit("mti_o", mti_o, s.exp[0]);
                end else begin
                    check_bit("mei_o", mei_o, s.exp[0]);
                end
            end
            OP_CREDIT: begin
                @(posedge clk_i);
                credit_mode <= s.wdata[1:0];
            end
            default: begin
                while (exp_flits.size() != 0) @(posedge clk_i);
                repeat (2) @(posedge clk_i);
            end
        endcase
    endtask

    task automatic build_table();
        // Data memory and an unmapped region
        add_step(OP_WRITE, 32'h0100_0010, 32'hCAFE_0010, 0, 0, 0);
        add_step(OP_READ, 32'h0100_0010, 0, 32'hCAFE_0010, 1, 0);
        add_step(OP_READ, 32'h0100_0A04, 0, fill_word(24'h000A04), 1, 0);
        add_step(OP_WRITE, 32'h1000_0000, 32'h0000_1234, 0, 0, 0);
        // RTC tick and compare
        add_step(OP_MARK, 32'h0200_0000, 0, 0, 0, 0);
        add_step(OP_WAIT, 0, 7, 0, 0, 0);
        add_step(OP_DELTA, 32'h0200_0000, 0, 0, 1, 0);
        add_step(OP_MTI, 0, 0, 0, 1, 0);
        add_step(OP_WRITE, 32'h0200_000C, 32'h0, 0, 0, 0);
        add_step(OP_CMP_REL, 32'h0200_0008, 20, 0, 0, 0);
        add_step(OP_MTI, 0, 0, 0, 1, 0);
        add_step(OP_WAIT, 0, 30, 0, 0, 0);
        add_step(OP_MTI, 0, 0, 1, 1, 0);
        add_step(OP_WRITE, 32'h0200_000C, 32'hFFFF_FFFF, 0, 0, 0);
        add_step(OP_MTI, 0, 0, 0, 1, 0);
        // Ten flits under random credit
        add_step(OP_CREDIT, 0, 2, 0, 0, 0);
        for (int k = 0; k < 10; k++) begin
            add_step(OP_WRITE, 32'h0800_0000, $urandom, 0, 0, 1);
        end
        add_step(OP_DRAIN, 0, 0, 0, 0, 0);
        add_step(OP_READ, 32'h0800_0004, 0, 32'h000A_0000, 1, 0);
        // Overflow with credit held low
        add_step(OP_CREDIT, 0, 0, 0, 0, 0);
        add_step(OP_WAIT, 0, 2, 0, 0, 0);
        for (int k = 0; k < DEPTH + 3; k++) begin
            add_step(OP_WRITE, 32'h0800_0000, $urandom, 0, 0, k < DEPTH + 1);
        end
        add_step(OP_READ, 32'h0800_0004, 0, {16'd10, 8'(DEPTH), 8'h01}, 1, 0);
        add_step(OP_CREDIT, 0, 1, 0, 0, 0);
        add_step(OP_DRAIN, 0, 0, 0, 0, 0);
        add_step(OP_READ, 32'h0800_0004, 0, {16'(11 + DEPTH), 8'h00, 8'h01}, 1, 0);
        // Interrupt chain through the PLIC
        add_step(OP_WRITE, 32'h0800_0008, 32'h1, 0, 0, 0);
        add_step(OP_WRITE, 32'h0400_0004, 32'h1, 0, 0, 0);
        add_step(OP_WAIT, 0, 2, 0, 0, 0);
        add_step(OP_MEI, 0, 0, 1, 1, 0);
        add_step(OP_READ, 32'h0400_0008, 0, 32'h1, 1, 0);
        add_step(OP_ACK, 0, 0, 0, 1, 0);
        add_step(OP_MEI, 0, 0, 1, 1, 0);
        add_step(OP_WRITE, 32'h0800_0008, 32'h0, 0, 0, 0);
        add_step(OP_ACK, 0, 0, 0, 1, 0);
        add_step(OP_WAIT, 0, 3, 0, 0, 0);
        add_step(OP_MEI, 0, 0, 0, 1, 0);
    endtask

    initial begin
        bus_en_i     = 1'b0;
        bus_we_i     = 4'h0;
        bus_addr_i   = '0;
        bus_wdata_i  = '0;
        irq_ack_i    = 1'b0;
        noc_credit_i = 1'b1;
        credit_mode  = 2'd1;
        cycle_cnt    = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = fill_word(24'(i * 4));
        end
        void'($urandom(99));
        build_table();
        tests_ready = 1'b1;
        wait (rst_ni);
        @(posedge clk_i);
        // Outputs quiet straight after reset
        @(negedge clk_i);
        check_bit("mti_o", mti_o, 1'b0);
        check_bit("mei_o", mei_o, 1'b0);
        check_bit("noc_tx_o", noc_tx_o, 1'b0);
        check_bit("dmem_en_o", dmem_en_o, 1'b0);
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        repeat (4) @(posedge clk_i);
        if (exp_flits.size() != 0) begin
            fail_cnt++;
            $display("%0d expected flits never left the link", exp_flits.size());
        end
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $display("passed %0d failed %0d", pass_cnt, fail_cnt);
        $finish;
    end

    // Watchdog scaled to the table length
    initial begin
        wait (tests_ready);
        repeat (steps.size() * 20 + 200) @(posedge clk_i);
        $display("CHECKS FAILED");
        $display("timeout, the run did not finish in time");
        $finish;
    end

endmodule
